/* src.f */
verilog/flush_pkg.sv
verilog/flush_ctrl_if.sv
verilog/flush_controller.sv
verilog/dcache_flush_engine.sv
verilog/pc_redirect.sv
verilog/flush_top.sv
test/flush_checker.sv
test/flush_tb.sv

/* Makefile */
# Verilator build and run of the flush and redirect testbench

VERILATOR ?= verilator
TOP       ?= flush_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* test/flush_tb.sv */
// ---------------------------------------------------------------------
// Testbench for the flush and redirect top level
// Table of requests with expected strobes, redirect and halt length
// ---------------------------------------------------------------------

`timescale 1ns/1ns

module flush_tb;

    localparam int num_sets   = 8;   // Sets walked by the data cache flush
    localparam int num_tests  = 13;
    localparam int halt_limit = 64;  // Cycles before halt_o counts as stuck

    // Request bits: 0 eret, 1 exception, 2 debug, 3 fence, 4 fence.i, 5 sfence.vma,
    // 6 hfence.vvma, 7 hfence.gvma, 8 CSR, 9 commit, 10 halt CSR, 11 mispredict
    // Strobe bits high to low: if, unissued, id, ex, bp, set_pc_commit, icache,
    // tlb, tlb_vvma, tlb_gvma
    typedef struct packed {
        logic [11:0] req;
        logic        v;         // Guest mode
        logic [9:0]  strb;
        logic [1:0]  redir;     // 0 none, 1 branch target, 2 commit PC + 4, 3 trap PC
        logic        halt_now;  // Halt in the strobe cycle
        logic        drain;     // Write-back drain follows
    } row_t;

    localparam row_t tests [num_tests] = '{
        '{12'h000, 1'b0, 10'b0000000000, 2'd0, 1'b0, 1'b0},  // Idle
        '{12'h800, 1'b0, 10'b1100000000, 2'd1, 1'b0, 1'b0},  // Mispredict
        '{12'h008, 1'b0, 10'b1111010000, 2'd2, 1'b0, 1'b1},  // fence
        '{12'h010, 1'b0, 10'b1111011000, 2'd2, 1'b0, 1'b1},  // fence.i
        '{12'h020, 1'b0, 10'b1111010100, 2'd2, 1'b0, 1'b0},  // sfence.vma, host
        '{12'h020, 1'b1, 10'b1111010010, 2'd2, 1'b0, 1'b0},  // sfence.vma, guest
        '{12'h040, 1'b0, 10'b1111010010, 2'd2, 1'b0, 1'b0},  // hfence.vvma
        '{12'h080, 1'b0, 10'b1111010001, 2'd2, 1'b0, 1'b0},  // hfence.gvma
        '{12'h200, 1'b0, 10'b1111010000, 2'd2, 1'b0, 1'b0},  // Commit stage flush
        '{12'h102, 1'b0, 10'b1111100000, 2'd3, 1'b0, 1'b0},  // Exception with CSR flush
        '{12'h400, 1'b0, 10'b0000000000, 2'd0, 1'b1, 1'b0},  // WFI halt
        '{12'h001, 1'b0, 10'b1111100000, 2'd3, 1'b0, 1'b0},  // Exception return
        '{12'h804, 1'b0, 10'b1111100000, 2'd3, 1'b0, 1'b0}   // Debug beats mispredict
    };

    string strb_names [10] = '{"flush_tlb_gvma_o", "flush_tlb_vvma_o", "flush_tlb_o",
        "flush_icache_o", "set_pc_commit_o", "flush_bp_o", "flush_ex_o", "flush_id_o",
        "flush_unissued_o", "flush_if_o"};

    logic                   clk_i;
    logic                   rst_ni;
    logic                   v_i, halt_csr_i, eret_i, ex_valid_i, set_debug_pc_i;
    logic                   fence_i, fence_i_i, sfence_vma_i, hfence_vvma_i, hfence_gvma_i;
    logic                   flush_csr_i, flush_commit_i;
    flush_pkg::bp_resolve_t resolved_branch_i;
    flush_pkg::vaddr_t      commit_pc_i, trap_pc_i;
    logic                   flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o, flush_bp_o;
    logic                   set_pc_commit_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o;
    logic                   flush_tlb_gvma_o, flush_dcache_o, dcache_busy_o, halt_o;
    logic                   redirect_valid_o;
    flush_pkg::vaddr_t      redirect_pc_o;

    int errors = 0;
    int seed   = 32;

    flush_top dut0 (.*);

    always #5 clk_i = ~clk_i;  // 10 ns period

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_requests();
        {eret_i, ex_valid_i, set_debug_pc_i, fence_i, fence_i_i, sfence_vma_i} <= '0;
        {hfence_vvma_i, hfence_gvma_i, flush_csr_i, flush_commit_i, halt_csr_i} <= '0;
        resolved_branch_i <= '0;
    endtask

    // One table row onto the request inputs
    task automatic drive_row(input row_t r, input flush_pkg::vaddr_t tgt,
                             input flush_pkg::vaddr_t cpc, input flush_pkg::vaddr_t tpc);
        {hfence_gvma_i, hfence_vvma_i, sfence_vma_i, fence_i_i, fence_i} <= r.req[7:3];
        {set_debug_pc_i, ex_valid_i, eret_i} <= r.req[2:0];
        {halt_csr_i, flush_commit_i, flush_csr_i} <= r.req[10:8];
        v_i               <= r.v;
        resolved_branch_i <= '{valid: r.req[11], is_mispredict: r.req[11],
                               target_address: tgt};
        commit_pc_i       <= cpc;
        trap_pc_i         <= tpc;
    endtask

    function automatic flush_pkg::vaddr_t expected_pc(input logic [1:0] code,
        input flush_pkg::vaddr_t tgt, input flush_pkg::vaddr_t cpc,
        input flush_pkg::vaddr_t tpc);
        case (code)
            2'd1:    return tgt;
            2'd2:    return cpc + 32'd4;  // Instruction after the one at commit
            default: return tpc;
        endcase
    endfunction

    initial begin
        row_t              row;
        flush_pkg::vaddr_t tgt, cpc, tpc;
        logic [9:0]        got_strb;
        int                halt_cnt, busy_cnt, err_before, failed;

        failed      = 0;
        clk_i       = 1'b0;
        rst_ni      <= 1'b0;
        v_i         <= 1'b0;
        commit_pc_i <= '0;
        trap_pc_i   <= '0;
        clear_requests();
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        compare_bit("flush_dcache_o", flush_dcache_o, 1'b0);  // Quiet after reset
        compare_bit("halt_o", halt_o, 1'b0);
        compare_bit("redirect_valid_o", redirect_valid_o, 1'b0);

        for (int t = 0; t < num_tests; t++) begin
            row        = tests[t];
            err_before = errors;
            tgt        = $random(seed);
            cpc        = $random(seed);
            tpc        = $random(seed);
            @(posedge clk_i);
            drive_row(row, tgt, cpc, tpc);
            @(negedge clk_i);  // Strobes are combinational, sample mid cycle
            got_strb = {flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o, flush_bp_o,
                        set_pc_commit_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o,
                        flush_tlb_gvma_o};
            for (int i = 0; i < 10; i++) begin
                compare_bit(strb_names[i], got_strb[i], row.strb[i]);
            end
            compare_bit("halt_o", halt_o, row.halt_now);
            @(posedge clk_i);
            clear_requests();

            // Redirect and dcache request show up one cycle after the strobe
            @(negedge clk_i);
            compare_bit("redirect_valid_o", redirect_valid_o, row.redir != 2'd0);
            if (row.redir != 2'd0) begin
                compare_word("redirect_pc_o", redirect_pc_o,
                             expected_pc(row.redir, tgt, cpc, tpc));
            end
            compare_bit("flush_dcache_o", flush_dcache_o, row.drain);

            // Halt length, walk length
            halt_cnt = 0;
            busy_cnt = 0;
            while (halt_o && halt_cnt < halt_limit) begin
                halt_cnt++;
                if (dcache_busy_o) begin
                    busy_cnt++;
                end
                @(negedge clk_i);
            end
            if (halt_o) begin
                $display("Test %0d: halt_o did not fall within %0d cycles", t, halt_limit);
                errors++;
            end else begin
                compare_word("halt_o cycles", halt_cnt, row.drain ? num_sets + 2 : 0);
                compare_word("dcache_busy_o cycles", busy_cnt, row.drain ? num_sets : 0);
            end

            if (errors == err_before) begin
                $display("Test %0d passed", t);
            end else begin
                failed++;
                $display("Test %0d failed with %0d errors", t, errors - err_before);
            end
        end

        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, num_tests - failed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* test/flush_checker.sv */
// ---------------------------------------------------------------------
// Assertions bound into the flush controller
// Data cache handshake, halt during drain, trap against commit restart
// ---------------------------------------------------------------------

`timescale 1ns/1ns

module flush_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_dcache_i,   // Level request to the data cache
    input logic ack_i,            // Flush done
    input logic halt_i,
    input logic ex_valid_i,
    input logic set_pc_commit_i
);

    // Acknowledge only answers a pending request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> flush_dcache_i) else $error("dcache ack without request");

    // Request held until the cache answers
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_dcache_i && !ack_i |=> flush_dcache_i) else $error("dcache request dropped");

    // Commit stays stopped for as long as the cache is asked to drain
    drain_halts: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_dcache_i |-> halt_i) else $error("dcache request without halt");

    // A trap restarts at the vector, never after commit
    trap_no_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ex_valid_i && set_pc_commit_i)) else $error("exception with set_pc_commit");

endmodule

bind flush_controller flush_checker chk0 (
    .clk_i,
    .rst_ni,
    .flush_dcache_i  (flush_dcache_o),
    .ack_i           (flush_dcache_ack_i),
    .halt_i          (halt_o),
    .ex_valid_i,
    .set_pc_commit_i (ctrl.set_pc_commit)
);

/* verilog/flush_top.sv */
// ---------------------------------------------------------------------
// Flush and redirect top level
// Controller, data cache flush engine and redirect unit
// ---------------------------------------------------------------------

`timescale 1ns/1ns

module flush_top #(
    parameter flush_pkg::dcache_kind_e DcacheKind = flush_pkg::dcache_wb,
    parameter int unsigned             NumSets    = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   v_i,
    input  logic                   halt_csr_i,
    input  logic                   eret_i,
    input  logic                   ex_valid_i,
    input  logic                   set_debug_pc_i,
    input  logic                   fence_i,
    input  logic                   fence_i_i,
    input  logic                   sfence_vma_i,
    input  logic                   hfence_vvma_i,
    input  logic                   hfence_gvma_i,
    input  logic                   flush_csr_i,
    input  logic                   flush_commit_i,
    input  flush_pkg::bp_resolve_t resolved_branch_i,
    input  flush_pkg::vaddr_t      commit_pc_i,
    input  flush_pkg::vaddr_t      trap_pc_i,
    output logic                   flush_if_o,
    output logic                   flush_unissued_o,
    output logic                   flush_id_o,
    output logic                   flush_ex_o,
    output logic                   flush_bp_o,
    output logic                   set_pc_commit_o,
    output logic                   flush_icache_o,
    output logic                   flush_tlb_o,
    output logic                   flush_tlb_vvma_o,
    output logic                   flush_tlb_gvma_o,
    output logic                   flush_dcache_o,
    output logic                   dcache_busy_o,
    output logic                   halt_o,
    output logic                   redirect_valid_o,
    output flush_pkg::vaddr_t      redirect_pc_o
);

    flush_ctrl_if fl_if ();

    logic flush_dcache_ack;  // From engine back to controller

    flush_controller #(
        .DcacheKind (DcacheKind)
    ) ctrl0 (
        .clk_i, .rst_ni, .v_i, .halt_csr_i, .eret_i, .ex_valid_i, .set_debug_pc_i,
        .fence_i, .fence_i_i, .sfence_vma_i, .hfence_vvma_i, .hfence_gvma_i,
        .flush_csr_i, .flush_commit_i,
        .flush_dcache_ack_i (flush_dcache_ack),
        .resolved_branch_i,
        .flush_icache_o, .flush_tlb_o, .flush_tlb_vvma_o, .flush_tlb_gvma_o,
        .flush_dcache_o, .halt_o,
        .ctrl               (fl_if.ctrl)
    );

    dcache_flush_engine #(
        .NumSets (NumSets)
    ) dflush0 (
        .clk_i, .rst_ni,
        .flush_i (flush_dcache_o),
        .ack_o   (flush_dcache_ack),
        .busy_o  (dcache_busy_o)
    );

    pc_redirect redir0 (
        .clk_i, .rst_ni, .commit_pc_i, .trap_pc_i, .resolved_branch_i,
        .fl               (fl_if.redirect),
        .redirect_valid_o,
        .redirect_pc_o
    );

    // Pipeline bundle out to the stages
    assign flush_if_o       = fl_if.flush_if;
    assign flush_unissued_o = fl_if.flush_unissued;
    assign flush_id_o       = fl_if.flush_id;
    assign flush_ex_o       = fl_if.flush_ex;
    assign flush_bp_o       = fl_if.flush_bp;
    assign set_pc_commit_o  = fl_if.set_pc_commit;

endmodule

/* verilog/pc_redirect.sv */
// ---------------------------------------------------------------------
// Redirect unit
// Registers the next fetch PC chosen by the flush cause
// ---------------------------------------------------------------------

`timescale 1ns/1ns

module pc_redirect (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  flush_pkg::vaddr_t      commit_pc_i,  // PC of the committing instruction
    input  flush_pkg::vaddr_t      trap_pc_i,    // Trap, return or debug vector
    input  flush_pkg::bp_resolve_t resolved_branch_i,
    flush_ctrl_if.redirect         fl,
    output logic                   redirect_valid_o,
    output flush_pkg::vaddr_t      redirect_pc_o
);

    flush_pkg::vaddr_t next_pc;
    logic              next_valid;

    // ------------------------------------------------------------------
    // Target select
    // ------------------------------------------------------------------
    always_comb begin
        next_pc    = resolved_branch_i.target_address;
        next_valid = 1'b1;
        case (fl.cause)
            flush_pkg::redir_trap:       next_pc = trap_pc_i;
            // Restart right after the instruction that caused the flush
            flush_pkg::redir_commit:     next_pc = commit_pc_i + flush_pkg::vaddr_t'(4);
            flush_pkg::redir_mispredict: next_pc = resolved_branch_i.target_address;
            default:                     next_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= next_valid;
        end
    end

    // PC only matters with the valid
    always_ff @(posedge clk_i) begin
        redirect_pc_o <= next_pc;
    end

endmodule

/* verilog/dcache_flush_engine.sv */
// ---------------------------------------------------------------------
// Write-back data cache flush model
// Walks every set once per request and acknowledges for one cycle
// ---------------------------------------------------------------------

`timescale 1ns/1ns

module dcache_flush_engine #(
    parameter int unsigned NumSets = 8
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,  // Level request from the controller
    output logic ack_o,    // One cycle, flush complete
    output logic busy_o    // Set walk in progress
);

    localparam int unsigned CntW = (NumSets > 1) ? $clog2(NumSets) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_walk,
        st_ack
    } state_e;

    state_e            state_q, state_d;
    logic [CntW-1:0]   set_q, set_d;  // Set being written back
    logic              last_set;

    assign last_set = (set_q == CntW'(NumSets - 1));

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        set_d   = set_q;
        case (state_q)
            st_idle: begin
                if (flush_i) begin
                    state_d = st_walk;
                    set_d   = '0;
                end
            end
            st_walk: begin
                // One set per cycle, dirty lines go out to memory
                if (last_set) state_d = st_ack;
                else          set_d   = set_q + 1'b1;
            end
            st_ack:  state_d = st_idle;  // Request still high here, ignored
            default: state_d = st_idle;
        endcase
    end

    assign ack_o  = (state_q == st_ack);
    assign busy_o = (state_q == st_walk);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= st_idle;
            set_q   <= '0;
        end else begin
            state_q <= state_d;
            set_q   <= set_d;
        end
    end

endmodule

/* verilog/flush_controller.sv */
// ---------------------------------------------------------------------
// Flush controller
// Priority merge of flush requests into pipeline, TLB and cache strobes
// Fence tracking with data-cache flush request and commit halt
// ---------------------------------------------------------------------

`timescale 1ns/1ns

module flush_controller #(
    parameter flush_pkg::dcache_kind_e DcacheKind = flush_pkg::dcache_wb
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   v_i,                // Guest mode
    input  logic                   halt_csr_i,         // WFI style halt from CSR file
    input  logic                   eret_i,             // Exception return
    input  logic                   ex_valid_i,         // Exception taken
    input  logic                   set_debug_pc_i,     // Debug entry
    input  logic                   fence_i,            // fence
    input  logic                   fence_i_i,          // fence.i
    input  logic                   sfence_vma_i,
    input  logic                   hfence_vvma_i,
    input  logic                   hfence_gvma_i,
    input  logic                   flush_csr_i,        // CSR write with side effects
    input  logic                   flush_commit_i,     // Flush asked by commit stage
    input  logic                   flush_dcache_ack_i, // Data cache done flushing
    input  flush_pkg::bp_resolve_t resolved_branch_i,
    output logic                   flush_icache_o,
    output logic                   flush_tlb_o,
    output logic                   flush_tlb_vvma_o,
    output logic                   flush_tlb_gvma_o,
    output logic                   flush_dcache_o,     // Level request to the data cache
    output logic                   halt_o,             // Stop commit
    flush_ctrl_if.ctrl             ctrl
);

    localparam bit IsWb = (DcacheKind == flush_pkg::dcache_wb);

    logic fence_active_d, fence_active_q; // Waiting for the data cache to drain
    logic flush_dcache_d;
    logic full_flush;                     // Flush of every stage behind commit
    logic mispredict;
    logic trap;

    assign mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;
    assign trap       = ex_valid_i | eret_i | set_debug_pc_i;
    assign full_flush = fence_i | fence_i_i | sfence_vma_i | hfence_vvma_i | hfence_gvma_i
                      | flush_csr_i | flush_commit_i;

    // ------------------------------------------------------------------
    // Flush priority, later assignments win
    // ------------------------------------------------------------------
    always_comb begin
        ctrl.flush_if       = 1'b0;
        ctrl.flush_unissued = 1'b0;
        ctrl.flush_id       = 1'b0;
        ctrl.flush_ex       = 1'b0;
        ctrl.flush_bp       = 1'b0;
        ctrl.set_pc_commit  = 1'b0;
        ctrl.cause          = flush_pkg::redir_none;
        flush_icache_o      = 1'b0;
        flush_tlb_o         = 1'b0;
        flush_tlb_vvma_o    = 1'b0;
        flush_tlb_gvma_o    = 1'b0;
        flush_dcache_d      = 1'b0;
        fence_active_d      = fence_active_q;

        // Lowest priority, only the front end is wrong
        if (mispredict) begin
            ctrl.flush_if       = 1'b1;
            ctrl.flush_unissued = 1'b1;
            ctrl.cause          = flush_pkg::redir_mispredict;
        end

        // Fences, TLB fences, CSR and commit flushes all restart after commit
        if (full_flush) begin
            ctrl.set_pc_commit  = 1'b1;
            ctrl.flush_if       = 1'b1;
            ctrl.flush_unissued = 1'b1;
            ctrl.flush_id       = 1'b1;
            ctrl.flush_ex       = 1'b1;
            ctrl.cause          = flush_pkg::redir_commit;
        end

        if (fence_i_i) flush_icache_o = 1'b1;  // Stale instructions after self-modifying code

        // Only a write-back cache holds dirty data
        if (IsWb && (fence_i || fence_i_i)) begin
            flush_dcache_d = 1'b1;
            fence_active_d = 1'b1;
        end

        // Hold the request until the cache answers
        if (IsWb && fence_active_q) begin
            if (flush_dcache_ack_i) begin
                fence_active_d = 1'b0;
            end else begin
                flush_dcache_d = 1'b1;
            end
        end

        // sfence.vma hits the guest TLB when running virtualized
        if (sfence_vma_i) begin
            if (v_i) flush_tlb_vvma_o = 1'b1;
            else     flush_tlb_o      = 1'b1;
        end
        if (hfence_vvma_i) flush_tlb_vvma_o = 1'b1;
        if (hfence_gvma_i) flush_tlb_gvma_o = 1'b1;

        // Highest priority, fetch goes to the trap or return vector
        if (trap) begin
            ctrl.set_pc_commit  = 1'b0;
            ctrl.flush_if       = 1'b1;
            ctrl.flush_unissued = 1'b1;
            ctrl.flush_id       = 1'b1;
            ctrl.flush_ex       = 1'b1;
            ctrl.flush_bp       = 1'b1;  // No speculative fetch from the old context
            ctrl.cause          = flush_pkg::redir_trap;
        end
    end

    // Commit waits for WFI or for the data cache to drain
    assign halt_o = halt_csr_i | (IsWb & fence_active_q);

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            flush_dcache_o <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            flush_dcache_o <= flush_dcache_d;  // Registered, goes a long way
        end
    end

endmodule

/* verilog/flush_ctrl_if.sv */
// ---------------------------------------------------------------------
// Pipeline flush bundle from the flush controller to the redirect unit
// ---------------------------------------------------------------------

`timescale 1ns/1ns

interface flush_ctrl_if;

    logic                 flush_if;       // Flush the fetch stage
    logic                 flush_unissued; // Drop instructions not yet issued
    logic                 flush_id;       // Flush decode
    logic                 flush_ex;       // Flush execute
    logic                 flush_bp;       // Flush branch predictors
    logic                 set_pc_commit;  // Restart fetch after the committing instr
    flush_pkg::redirect_e cause;          // Reason for the redirect

    // Driver side, the flush controller
    modport ctrl (
        output flush_if, flush_unissued, flush_id, flush_ex, flush_bp,
        output set_pc_commit, cause
    );

    // Consumer side, redirect unit and top level outputs
    modport redirect (
        input flush_if, flush_unissued, flush_id, flush_ex, flush_bp,
        input set_pc_commit, cause
    );

endinterface

/* verilog/flush_pkg.sv */
// ---------------------------------------------------------------------
// Shared definitions for the flush and redirect block
// Address width, resolved-branch struct, cache policy and redirect cause
// ---------------------------------------------------------------------

package flush_pkg;

    // Address width of PCs and branch targets
    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] vaddr_t;

    // Resolved branch coming back from the execute stage
    typedef struct packed {
        logic   valid;          // Branch resolved this cycle
        logic   is_mispredict;  // Front end went the wrong way
        vaddr_t target_address; // Correct target of the branch
    } bp_resolve_t;

    // Data cache write policy
    typedef enum logic {
        dcache_wt = 1'b0,  // Write-through, nothing dirty to flush
        dcache_wb = 1'b1   // Write-back, fences must drain dirty lines
    } dcache_kind_e;

    // Which source the next fetch PC comes from
    typedef enum logic [1:0] {
        redir_none       = 2'd0,
        redir_mispredict = 2'd1,
        redir_commit     = 2'd2,
        redir_trap       = 2'd3
    } redirect_e;

endpackage
